/* Makefile */
SIM := obj_dir/VpermutationPipelineTb
SOURCES := $(shell cat permutationPipeline.f)

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

$(SIM): permutationPipeline.f $(SOURCES)
	verilator --binary --timing --assert --top-module permutationPipelineTb \
		-f permutationPipeline.f -o VpermutationPipelineTb

clean:
	rm -rf obj_dir

/* permutationPipeline.f */
src/permutationPkg.sv
src/topReceiver.sv
src/botGenerator.sv
src/permuteLane.sv
src/laneResultFifo.sv
src/resultCombiner.sv
src/permutationPipeline.sv
tests/permutationPipeline_checker.sv
tests/permutationPipelineTb.sv

/* src/botGenerator.sv */
`default_nettype none

module botGenerator #(
    parameter int NUMBER_OF_LANES = 4
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  permutationPkg::botT        bot,
    input  logic                       writeBot,
    output logic                       readyForInputBot,
    input  logic [NUMBER_OF_LANES-1:0] laneAlmostFull,
    output permutationPkg::botT        laneBot,
    output logic                       laneBotValid
);

    localparam int QUEUE_DEPTH = 4;
    // Keeps one entry spare for the write already in flight
    localparam logic [2:0] READY_LIMIT = 3'd3;

    permutationPkg::botT queueMem [QUEUE_DEPTH];
    logic [1:0] wrPtr;
    logic [1:0] rdPtr;
    logic [2:0] queueCount;
    logic       laneStall;
    logic       push;
    logic       pop;

    assign push = writeBot && readyForInputBot;
    assign pop  = laneBotValid;

    assign readyForInputBot = queueCount < READY_LIMIT;
    assign laneBotValid     = (queueCount != 3'd0) && !laneStall;
    assign laneBot          = queueMem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            queueMem[wrPtr] <= bot;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            queueCount <= '0;
            laneStall  <= 1'b0;
        end else begin
            // Any lane nearing full holds the broadcast, one cycle late
            laneStall <= |laneAlmostFull;
            if (push) begin
                wrPtr <= wrPtr + 2'd1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 2'd1;
            end
            case ({push, pop})
                2'b10:   queueCount <= queueCount + 3'd1;
                2'b01:   queueCount <= queueCount - 3'd1;
                default: queueCount <= queueCount;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/laneResultFifo.sv */
`default_nettype none

module laneResultFifo #(
    parameter int RESULT_FIFO_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       write,
    input  permutationPkg::laneResultT dataIn,
    input  logic                       read,
    output permutationPkg::laneResultT dataOut,
    output logic                       notEmpty,
    output logic                       full
);

    localparam int PTR_W = (RESULT_FIFO_DEPTH > 1) ? $clog2(RESULT_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(RESULT_FIFO_DEPTH + 1);

    permutationPkg::laneResultT fifoMem [RESULT_FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] fill;
    logic             doWrite;
    logic             doRead;

    assign notEmpty = (fill != '0);
    assign full     = (fill == CNT_W'(RESULT_FIFO_DEPTH));
    assign doWrite  = write && !full;
    assign doRead   = read && notEmpty;
    assign dataOut  = fifoMem[rdPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            fifoMem[wrPtr] <= dataIn;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= (wrPtr == PTR_W'(RESULT_FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= (rdPtr == PTR_W'(RESULT_FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/permutationPipeline.sv */
`default_nettype none

module permutationPipeline #(
    parameter int NUMBER_OF_LANES   = 4,
    parameter int LANE_QUEUE_DEPTH  = 4,
    parameter int RESULT_FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  permutationPkg::topCmdT topChannel,
    input  permutationPkg::botT    bot,
    input  logic                   writeBot,
    output logic                   readyForInputBot,
    input  logic                   slowDown,
    output logic                   resultValid,
    output permutationPkg::sumT    pcoeffSum,
    output permutationPkg::countT  pcoeffCount
);

    permutationPkg::botT        top;
    permutationPkg::botT        laneBot;
    logic                       laneBotValid;
    logic [NUMBER_OF_LANES-1:0] laneAlmostFull;
    logic [NUMBER_OF_LANES-1:0] resultWrite;
    logic [NUMBER_OF_LANES-1:0] fifoFull;
    logic [NUMBER_OF_LANES-1:0] fifoNotEmpty;
    permutationPkg::laneResultT laneResult [NUMBER_OF_LANES];
    permutationPkg::laneResultT fifoHeads [NUMBER_OF_LANES];
    logic                       readAll;

    topReceiver topReceiver0 (
        .clk        (clk),
        .rstN       (rstN),
        .topChannel (topChannel),
        .top        (top)
    );

    botGenerator #(
        .NUMBER_OF_LANES (NUMBER_OF_LANES)
    ) botGenerator0 (
        .clk              (clk),
        .rstN             (rstN),
        .bot              (bot),
        .writeBot         (writeBot),
        .readyForInputBot (readyForInputBot),
        .laneAlmostFull   (laneAlmostFull),
        .laneBot          (laneBot),
        .laneBotValid     (laneBotValid)
    );

    // Lane i swaps variable 0 with variable i
    for (genvar i = 0; i < NUMBER_OF_LANES; i++) begin : gLane
        permuteLane #(
            .LANE_INDEX       (i),
            .LANE_QUEUE_DEPTH (LANE_QUEUE_DEPTH)
        ) lane (
            .clk            (clk),
            .rstN           (rstN),
            .top            (top),
            .laneBot        (laneBot),
            .laneBotValid   (laneBotValid),
            .laneAlmostFull (laneAlmostFull[i]),
            .fifoFull       (fifoFull[i]),
            .resultWrite    (resultWrite[i]),
            .laneResult     (laneResult[i])
        );

        laneResultFifo #(
            .RESULT_FIFO_DEPTH (RESULT_FIFO_DEPTH)
        ) resultFifo (
            .clk      (clk),
            .rstN     (rstN),
            .write    (resultWrite[i]),
            .dataIn   (laneResult[i]),
            .read     (readAll),
            .dataOut  (fifoHeads[i]),
            .notEmpty (fifoNotEmpty[i]),
            .full     (fifoFull[i])
        );
    end

    resultCombiner #(
        .NUMBER_OF_LANES (NUMBER_OF_LANES)
    ) resultCombiner0 (
        .clk         (clk),
        .rstN        (rstN),
        .heads       (fifoHeads),
        .notEmpty    (fifoNotEmpty),
        .slowDown    (slowDown),
        .readAll     (readAll),
        .resultValid (resultValid),
        .pcoeffSum   (pcoeffSum),
        .pcoeffCount (pcoeffCount)
    );

endmodule

`default_nettype wire

/* src/permutationPkg.sv */
`default_nettype none

package permutationPkg;

    // Truth table of a 7-variable function, bit k is the value for input k
    typedef logic [127:0] botT;

    // One lane's set-bit count, 0 to 128
    typedef logic [7:0] laneSumT;

    // Coefficient summed over all lanes
    typedef logic [15:0] sumT;

    // Number of lanes with a nonzero count
    typedef logic [3:0] countT;

    typedef struct packed {
        laneSumT laneSum;
        logic    nonZero;
    } laneResultT;

    // Commands on the serial top channel
    typedef enum logic [1:0] {
        topIdle   = 2'd0,
        topClear  = 2'd1,
        topShift0 = 2'd2,
        topShift1 = 2'd3
    } topCmdT;

    // Exchange variables varA and varB of a truth table
    function automatic botT varSwap(input botT b, input logic [2:0] varA,
                                    input logic [2:0] varB);
        botT swapped;
        logic [6:0] origIdx;
        logic [6:0] srcIdx;
        for (int k = 0; k < 128; k++) begin
            origIdx = 7'(k);
            srcIdx = origIdx;
            srcIdx[varA] = origIdx[varB];
            srcIdx[varB] = origIdx[varA];
            swapped[k] = b[srcIdx];
        end
        return swapped;
    endfunction

endpackage

`default_nettype wire

/* src/permuteLane.sv */
`default_nettype none

module permuteLane #(
    parameter int LANE_INDEX       = 0,
    parameter int LANE_QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  permutationPkg::botT        top,
    input  permutationPkg::botT        laneBot,
    input  logic                       laneBotValid,
    output logic                       laneAlmostFull,
    input  logic                       fifoFull,
    output logic                       resultWrite,
    output permutationPkg::laneResultT laneResult
);

    localparam int PTR_W = (LANE_QUEUE_DEPTH > 1) ? $clog2(LANE_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(LANE_QUEUE_DEPTH + 1);

    typedef enum logic [1:0] {idle, load, count, write} laneStateT;

    permutationPkg::botT queueMem [LANE_QUEUE_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] queueCount;
    logic             pop;

    laneStateT                state;
    permutationPkg::botT      maskedBot;
    permutationPkg::botT      workBot;
    logic [7:0]               loadMask;
    logic [7:0]               chunkMask;
    logic [7:0]               nextMask;
    logic [15:0]              selChunk;
    logic [4:0]               chunkOnes;
    permutationPkg::laneSumT  accSum;

    assign pop            = (state == load);
    assign laneAlmostFull = queueCount >= CNT_W'(LANE_QUEUE_DEPTH - 2);
    assign resultWrite    = (state == write) && !fifoFull;

    assign laneResult.laneSum = accSum;
    assign laneResult.nonZero = (accSum != '0);

    // Swap variable 0 with this lane's variable, then restrict to top
    assign maskedBot = permutationPkg::varSwap(queueMem[rdPtr], 3'd0, 3'(LANE_INDEX)) & top;

    // Drops the lowest remaining chunk
    assign nextMask = chunkMask & (chunkMask - 8'd1);

    always_comb begin
        for (int j = 0; j < 8; j++) begin
            loadMask[j] = |maskedBot[16*j +: 16];
        end
    end

    // Lowest pending chunk wins, so scan from the top down
    always_comb begin
        selChunk = '0;
        for (int j = 7; j >= 0; j--) begin
            if (chunkMask[j]) begin
                selChunk = workBot[16*j +: 16];
            end
        end
    end

    always_comb begin
        chunkOnes = '0;
        for (int b = 0; b < 16; b++) begin
            chunkOnes = chunkOnes + 5'(selChunk[b]);
        end
    end

    always_ff @(posedge clk) begin
        if (laneBotValid) begin
            queueMem[wrPtr] <= laneBot;
        end
        if (state == load) begin
            workBot <= maskedBot;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            queueCount <= '0;
        end else begin
            if (laneBotValid) begin
                wrPtr <= (wrPtr == PTR_W'(LANE_QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(LANE_QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({laneBotValid, pop})
                2'b10:   queueCount <= queueCount + 1'b1;
                2'b01:   queueCount <= queueCount - 1'b1;
                default: queueCount <= queueCount;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= idle;
            chunkMask <= '0;
            accSum    <= '0;
        end else begin
            case (state)
                idle: begin
                    if (queueCount != '0) begin
                        state <= load;
                    end
                end
                load: begin
                    chunkMask <= loadMask;
                    accSum    <= '0;
                    // An empty product skips counting
                    state     <= (loadMask == 8'd0) ? write : count;
                end
                count: begin
                    accSum    <= accSum + permutationPkg::laneSumT'(chunkOnes);
                    chunkMask <= nextMask;
                    if (nextMask == 8'd0) begin
                        state <= write;
                    end
                end
                write: begin
                    // Hold the result until the FIFO has room
                    if (!fifoFull) begin
                        state <= (queueCount != '0) ? load : idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/resultCombiner.sv */
`default_nettype none

module resultCombiner #(
    parameter int NUMBER_OF_LANES = 4
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  permutationPkg::laneResultT heads [NUMBER_OF_LANES],
    input  logic [NUMBER_OF_LANES-1:0] notEmpty,
    input  logic                       slowDown,
    output logic                       readAll,
    output logic                       resultValid,
    output permutationPkg::sumT        pcoeffSum,
    output permutationPkg::countT      pcoeffCount
);

    // Lanes below HALF go to the low partial sum, the rest to the high one
    localparam int HALF = (NUMBER_OF_LANES + 1) / 2;

    logic                       slowDownReg;
    logic [2:0]                 validPipe;
    permutationPkg::laneResultT headReg [NUMBER_OF_LANES];
    permutationPkg::sumT        loSumNext;
    permutationPkg::sumT        hiSumNext;
    permutationPkg::countT      loCntNext;
    permutationPkg::countT      hiCntNext;
    permutationPkg::sumT        loSum;
    permutationPkg::sumT        hiSum;
    permutationPkg::countT      loCnt;
    permutationPkg::countT      hiCnt;

    // All lanes read together so results stay aligned
    assign readAll     = (&notEmpty) && !slowDownReg;
    assign resultValid = validPipe[2];

    always_ff @(posedge clk) begin
        if (readAll) begin
            headReg <= heads;
        end
    end

    always_comb begin
        loSumNext = '0;
        hiSumNext = '0;
        loCntNext = '0;
        hiCntNext = '0;
        for (int i = 0; i < NUMBER_OF_LANES; i++) begin
            if (i < HALF) begin
                loSumNext = loSumNext + permutationPkg::sumT'(headReg[i].laneSum);
                loCntNext = loCntNext + permutationPkg::countT'(headReg[i].nonZero);
            end else begin
                hiSumNext = hiSumNext + permutationPkg::sumT'(headReg[i].laneSum);
                hiCntNext = hiCntNext + permutationPkg::countT'(headReg[i].nonZero);
            end
        end
    end

    // First adder stage
    always_ff @(posedge clk) begin
        loSum <= loSumNext;
        hiSum <= hiSumNext;
        loCnt <= loCntNext;
        hiCnt <= hiCntNext;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slowDownReg <= 1'b0;
            validPipe   <= '0;
            pcoeffSum   <= '0;
            pcoeffCount <= '0;
        end else begin
            slowDownReg <= slowDown;
            validPipe   <= {validPipe[1:0], readAll};
            // Second adder stage joins the two halves
            pcoeffSum   <= loSum + hiSum;
            pcoeffCount <= loCnt + hiCnt;
        end
    end

endmodule

`default_nettype wire

/* src/topReceiver.sv */
`default_nettype none

module topReceiver (
    input  logic                   clk,
    input  logic                   rstN,
    input  permutationPkg::topCmdT topChannel,
    output permutationPkg::botT    top
);

    // Earlier bits move toward bit 127 as new ones enter at bit 0
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            top <= '0;
        end else begin
            case (topChannel)
                permutationPkg::topClear: begin
                    top <= '0;
                end
                permutationPkg::topShift0: begin
                    top <= {top[126:0], 1'b0};
                end
                permutationPkg::topShift1: begin
                    top <= {top[126:0], 1'b1};
                end
                default: begin
                    top <= top;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tests/permutationPipelineTb.sv */
`default_nettype none

module permutationPipelineTb;

    localparam int LANES = 4;
    // Roughly 200 bots at worst-case lane latency, top loads and the slowDown hold
    localparam int MAX_BOTS = 200;
    localparam int BOT_CYCLES = 12;
    localparam int FIXED_CYCLES = 1600;
    localparam int TIMEOUT_CYCLES = 5 * (MAX_BOTS * BOT_CYCLES + FIXED_CYCLES);

    logic                   clk = 1'b0;
    logic                   rstN;
    permutationPkg::topCmdT topChannel;
    permutationPkg::botT    bot;
    logic                   writeBot;
    logic                   readyForInputBot;
    logic                   slowDown;
    logic                   resultValid;
    permutationPkg::sumT    pcoeffSum;
    permutationPkg::countT  pcoeffCount;

    permutationPkg::botT topModel;
    int          expSum [$];
    int          expCount [$];
    logic [31:0] rngState;
    int          cycleCount = 0;
    int          resultCount = 0;
    int          monitorErrors = 0;
    int          stimErrors;
    int          errorsBefore;
    int          testsPassed;
    int          testsFailed;
    int          heldBefore;

    permutationPipeline #(
        .NUMBER_OF_LANES (LANES)
    ) dut0 (
        .clk              (clk),
        .rstN             (rstN),
        .topChannel       (topChannel),
        .bot              (bot),
        .writeBot         (writeBot),
        .readyForInputBot (readyForInputBot),
        .slowDown         (slowDown),
        .resultValid      (resultValid),
        .pcoeffSum        (pcoeffSum),
        .pcoeffCount      (pcoeffCount)
    );

    bind permutationPipeline permutationPipeline_checker checker0 (
        .clk              (clk),
        .rstN             (rstN),
        .writeBot         (writeBot),
        .readyForInputBot (readyForInputBot),
        .readAll          (readAll),
        .slowDown         (slowDown),
        .resultValid      (resultValid),
        .pcoeffSum        (pcoeffSum),
        .pcoeffCount      (pcoeffCount)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic int totalErrors();
        return monitorErrors + stimErrors + int'(dut0.checker0.failCount);
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic permutationPkg::botT randomBot();
        return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
    endfunction

    // Bit k of the result is bit j of src, j being k with index bits varA and varB exchanged
    function automatic permutationPkg::botT swapVariables(input permutationPkg::botT src,
                                                          input int varA, input int varB);
        permutationPkg::botT swapped;
        int bitA;
        int bitB;
        int keep;
        for (int k = 0; k < 128; k++) begin
            bitA = (k >> varA) & 1;
            bitB = (k >> varB) & 1;
            keep = k & ~((1 << varA) | (1 << varB));
            swapped[7'(k)] = src[7'(keep | (bitA << varB) | (bitB << varA))];
        end
        return swapped;
    endfunction

    task automatic pushExpected(input permutationPkg::botT b);
        int sum;
        int nonZeroLanes;
        int ones;
        sum = 0;
        nonZeroLanes = 0;
        for (int lane = 0; lane < LANES; lane++) begin
            ones = $countones(swapVariables(b, 0, lane) & topModel);
            sum += ones;
            if (ones != 0) begin
                nonZeroLanes++;
            end
        end
        expSum.push_back(sum);
        expCount.push_back(nonZeroLanes);
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    // Most significant bit goes first, it ends up at bit 127
    task automatic loadTop(input permutationPkg::botT value);
        topChannel = permutationPkg::topClear;
        stepCycle();
        for (int i = 127; i >= 0; i--) begin
            topChannel = value[7'(i)] ? permutationPkg::topShift1 : permutationPkg::topShift0;
            stepCycle();
        end
        topChannel = permutationPkg::topIdle;
        topModel = value;
    endtask

    task automatic sendBot(input permutationPkg::botT b);
        while (!readyForInputBot) begin
            stepCycle();
        end
        bot = b;
        writeBot = 1'b1;
        pushExpected(b);
        stepCycle();
        writeBot = 1'b0;
    endtask

    // A few spare cycles let a stray extra result show up
    task automatic waitDrained();
        while (expSum.size() != 0) begin
            stepCycle();
        end
        repeat (10) stepCycle();
    endtask

    task automatic checkIdle();
        assert (resultValid == 1'b0) else begin
            $display("ERROR at time %0t: resultValid expected 0, got %0d", $time, resultValid);
            stimErrors++;
        end
        assert (readyForInputBot == 1'b1) else begin
            $display("ERROR at time %0t: readyForInputBot expected 1, got %0d",
                     $time, readyForInputBot);
            stimErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        if (totalErrors() == errorsBefore) begin
            testsPassed++;
            $display("%s: passed", name);
        end else begin
            testsFailed++;
            $display("%s: failed", name);
        end
        errorsBefore = totalErrors();
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rstN && resultValid) begin
            resultCount++;
            if (expSum.size() == 0) begin
                $display("ERROR at time %0t: result appeared with no bot outstanding", $time);
                monitorErrors++;
            end else begin
                assert (pcoeffSum == 16'(expSum[0])) else begin
                    $display("ERROR at time %0t: pcoeffSum expected %0d, got %0d",
                             $time, expSum[0], pcoeffSum);
                    monitorErrors++;
                end
                assert (pcoeffCount == 4'(expCount[0])) else begin
                    $display("ERROR at time %0t: pcoeffCount expected %0d, got %0d",
                             $time, expCount[0], pcoeffCount);
                    monitorErrors++;
                end
                void'(expSum.pop_front());
                void'(expCount.pop_front());
            end
        end
    end

    initial begin
        wait (cycleCount >= TIMEOUT_CYCLES);
        $display("timeout, results missing after %0d cycles", cycleCount);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        topChannel = permutationPkg::topIdle;
        bot = '0;
        writeBot = 1'b0;
        slowDown = 1'b0;
        topModel = '0;
        rngState = 32'd21;
        stimErrors = 0;
        errorsBefore = 0;
        testsPassed = 0;
        testsFailed = 0;

        repeat (8) begin
            @(negedge clk);
            checkIdle();
        end
        stepCycle();
        rstN = 1'b1;
        repeat (20) begin
            @(negedge clk);
            checkIdle();
        end
        stepCycle();
        finishTest("reset state");

        loadTop('1);
        repeat (30) sendBot(randomBot());
        waitDrained();
        finishTest("all-ones top");

        loadTop(randomBot());
        repeat (30) sendBot(randomBot());
        waitDrained();
        finishTest("random top");

        sendBot('0);
        for (int c = 0; c < 8; c++) begin
            sendBot(permutationPkg::botT'(16'(nextRandom())) << (16 * c));
        end
        sendBot(permutationPkg::botT'(1) << 127);
        sendBot('0);
        waitDrained();
        finishTest("zero and sparse bots");

        heldBefore = resultCount;
        repeat (60) sendBot(randomBot());
        waitDrained();
        assert (resultCount - heldBefore == 60) else begin
            $display("ERROR at time %0t: result count expected 60, got %0d",
                     $time, resultCount - heldBefore);
            stimErrors++;
        end
        finishTest("input back-pressure");

        fork
            begin
                repeat (40) sendBot(randomBot());
            end
            begin
                repeat (10) stepCycle();
                slowDown = 1'b1;
                heldBefore = resultCount;
                repeat (100) stepCycle();
                assert (resultCount - heldBefore <= 4) else begin
                    $display("ERROR at time %0t: %0d results arrived under slowDown, 4 allowed",
                             $time, resultCount - heldBefore);
                    stimErrors++;
                end
                slowDown = 1'b0;
            end
        join
        waitDrained();
        finishTest("output back-pressure");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, totalErrors());
        if (totalErrors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/permutationPipeline_checker.sv */
`default_nettype none

module permutationPipeline_checker (
    input logic                  clk,
    input logic                  rstN,
    input logic                  writeBot,
    input logic                  readyForInputBot,
    input logic                  readAll,
    input logic                  slowDown,
    input logic                  resultValid,
    input permutationPkg::sumT   pcoeffSum,
    input permutationPkg::countT pcoeffCount
);

    int unsigned writeFails = 0;
    int unsigned timingFails = 0;
    int unsigned slowFails = 0;
    int unsigned knownFails = 0;
    int unsigned failCount;
    // Consecutive cycles with slowDown high, saturating at 7
    logic [2:0]  slowRun;

    assign failCount = writeFails + timingFails + slowFails + knownFails;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slowRun <= '0;
        end else if (!slowDown) begin
            slowRun <= '0;
        end else if (slowRun != 3'd7) begin
            slowRun <= slowRun + 3'd1;
        end
    end

    writeOnlyWhenReady: assert property (@(posedge clk) disable iff (!rstN)
        writeBot |-> readyForInputBot)
    else begin
        writeFails++;
        $error("writeBot while readyForInputBot is low");
    end

    // Head register plus two adder stages
    validAfterRead: assert property (@(posedge clk) disable iff (!rstN)
        resultValid == $past(readAll, 3))
    else begin
        timingFails++;
        $error("resultValid not exactly 3 cycles after readAll");
    end

    // Fifth consecutive high cycle and later
    quietUnderSlowDown: assert property (@(posedge clk) disable iff (!rstN)
        (slowDown && slowRun >= 3'd4) |-> !resultValid)
    else begin
        slowFails++;
        $error("resultValid while slowDown held for 5 cycles");
    end

    // Sum and count only carry meaning alongside resultValid
    outputsKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({resultValid, readyForInputBot})
        && (!resultValid || !$isunknown({pcoeffSum, pcoeffCount})))
    else begin
        knownFails++;
        $error("unknown value on a DUT output");
    end

endmodule

`default_nettype wire
